/* hdl/mac_pkg.sv */
package mac_pkg;

  // ==========================================================================
  // widths
  // ==========================================================================
  localparam int ADDR_W      = 16;                  // microaddress width.
  localparam int MCA_W       = 10;                  // control-store address.
  localparam int COND_W      = 8;                   // condition flags.
  localparam int STACK_DEPTH = 4;                   // return stack entries.

  localparam int OP_W   = 3;                        // opcode field.
  localparam int TGT_W  = 13;                       // jump target field.
  localparam int CIDX_W = $clog2(COND_W);           // condition index field.
  localparam int DISP_W = 10;                       // conditional displacement.

  localparam int PTR_W   = $clog2(STACK_DEPTH);     // stack slot index.
  localparam int DEPTH_W = $clog2(STACK_DEPTH + 1); // fill count, 0 to 4.

  // ==========================================================================
  // microword opcodes
  // ==========================================================================
  localparam logic [OP_W-1:0] OP_CONT  = 3'd0;      // step to lca + 1.
  localparam logic [OP_W-1:0] OP_JMP   = 3'd1;      // absolute jump.
  localparam logic [OP_W-1:0] OP_JCOND = 3'd2;      // page-relative cond jump.
  localparam logic [OP_W-1:0] OP_CALL  = 3'd3;      // jump and push return.
  localparam logic [OP_W-1:0] OP_RET   = 3'd4;      // pop return address.
  localparam logic [OP_W-1:0] OP_JCD   = 3'd5;      // jump to data bus.
  // codes 6 and 7 are spare and sequence like OP_CONT

  // ==========================================================================
  // microword layouts
  // ==========================================================================
  // the same 16 bits read either as a jump word or as a conditional word,
  // the opcode sits in the top three bits of both.
  typedef union packed {
    struct packed {
      logic [OP_W-1:0]   op;                        // opcode.
      logic [TGT_W-1:0]  target;                    // absolute target.
    } jmp;
    struct packed {
      logic [OP_W-1:0]   op;                        // opcode.
      logic [CIDX_W-1:0] idx;                       // which flag to test.
      logic [DISP_W-1:0] disp;                      // low address bits.
    } cnd;
  } mac_word_u;

endpackage

/* hdl/mac_branch_decode.sv */
`timescale 1ns/10ps

module mac_branch_decode (
  input  logic [15:0]                 uword,
  input  logic [mac_pkg::COND_W-1:0]  cond,
  input  logic [mac_pkg::ADDR_W-1:0]  lca,
  input  logic                        hold,
  output logic                        hold_sel,
  output logic                        psel,
  output logic                        addsel,
  output logic                        cdsel,
  output logic                        nlcasel,
  output logic [mac_pkg::ADDR_W-1:0]  add,
  output logic                        push,
  output logic                        pop
);

  import mac_pkg::*;

  mac_word_u         word;
  logic [ADDR_W-1:0] jmp_addr;
  logic [ADDR_W-1:0] cnd_addr;
  logic              cond_hit;

  assign word = uword;                                  // reinterpret the bus.

  // ==========================================================================
  // branch target candidates
  // ==========================================================================
  assign jmp_addr = {{(ADDR_W - TGT_W){1'b0}}, word.jmp.target};  // zero extend.
  assign cnd_addr = {lca[ADDR_W-1:DISP_W], word.cnd.disp};        // stay in page.
  assign cond_hit = cond[word.cnd.idx];                           // flag under test.

  // ==========================================================================
  // select and strobe decode
  // ==========================================================================
  always_comb begin
    hold_sel = 1'b0;
    psel     = 1'b0;
    addsel   = 1'b0;
    cdsel    = 1'b0;
    nlcasel  = 1'b0;
    push     = 1'b0;
    pop      = 1'b0;
    add      = '0;

    if (hold) begin
      hold_sel = 1'b1;                                  // freeze lca and stack.
    end else begin
      case (word.jmp.op)
        OP_CONT: begin
          nlcasel = 1'b1;
        end
        OP_JMP: begin
          addsel = 1'b1;
          add    = jmp_addr;
        end
        OP_JCOND: begin
          if (cond_hit) begin
            addsel = 1'b1;
            add    = cnd_addr;
          end else begin
            nlcasel = 1'b1;                             // not taken.
          end
        end
        OP_CALL: begin
          addsel = 1'b1;
          add    = jmp_addr;
          push   = 1'b1;                                // saves nlca of the call.
        end
        OP_RET: begin
          psel = 1'b1;
          pop  = 1'b1;
        end
        OP_JCD: begin
          cdsel = 1'b1;
        end
        default: begin
          nlcasel = 1'b1;                               // spare codes fall through.
        end
      endcase
    end
  end

endmodule

/* hdl/mac_return_stack.sv */
`timescale 1ns/10ps

module mac_return_stack (
  input  logic                        mclk,
  input  logic                        rst_n,
  input  logic                        push,
  input  logic                        pop,
  input  logic [mac_pkg::ADDR_W-1:0]  push_data,
  output logic [mac_pkg::ADDR_W-1:0]  pr,
  output logic                        stack_fault
);

  import mac_pkg::*;

  logic [ADDR_W-1:0]  stack_mem [STACK_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;                           // next free slot.
  logic [PTR_W-1:0]   top_ptr;                          // newest entry.
  logic [DEPTH_W-1:0] depth;
  logic               empty;
  logic               full;

  assign top_ptr = wr_ptr - 1'b1;                       // wraps around the ring.
  assign empty   = (depth == '0);
  assign full    = (depth == DEPTH_W'(STACK_DEPTH));

  assign pr = empty ? '0 : stack_mem[top_ptr];          // zero when nothing saved.

  // ==========================================================================
  // storage
  // ==========================================================================
  // when full, wr_ptr already points at the oldest entry, so a push
  // simply overwrites it.
  always_ff @(posedge mclk) begin
    if (push) begin
      stack_mem[wr_ptr] <= push_data;
    end
  end

  // ==========================================================================
  // pointer and fill count
  // ==========================================================================
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      depth  <= '0;
    end else if (push) begin
      wr_ptr <= wr_ptr + 1'b1;
      if (!full) begin
        depth <= depth + 1'b1;                          // saturates at four.
      end
    end else if (pop && !empty) begin
      wr_ptr <= top_ptr;
      depth  <= depth - 1'b1;
    end
  end

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      stack_fault <= 1'b0;
    end else if ((pop && empty) || (push && full)) begin
      stack_fault <= 1'b1;                              // sticky until reset.
    end
  end

  a_depth_bound : assert property (
    @(posedge mclk) disable iff (!rst_n)
    depth <= DEPTH_W'(STACK_DEPTH)
  );

endmodule

/* hdl/mac_addr_select.sv */
`timescale 1ns/10ps

module mac_addr_select (
  input  logic                        mclk,
  input  logic                        rst_n,
  input  logic                        hold_sel,
  input  logic                        psel,
  input  logic                        addsel,
  input  logic                        cdsel,
  input  logic                        nlcasel,
  input  logic                        eccr_hi_n,
  input  logic [mac_pkg::ADDR_W-1:0]  pr,
  input  logic [mac_pkg::ADDR_W-1:0]  add,
  input  logic [mac_pkg::ADDR_W-1:0]  cd,
  output logic [mac_pkg::ADDR_W-1:0]  lca,
  output logic [mac_pkg::ADDR_W-1:0]  nlca,
  output logic [mac_pkg::MCA_W-1:0]   mca,
  output logic                        eccr
);

  import mac_pkg::*;

  logic [ADDR_W-1:0] ica;                               // next microaddress.

  // ==========================================================================
  // and-or source mux
  // ==========================================================================
  // each source is gated by its own select and the gated terms are ored,
  // so the selects have to stay one-hot for a clean result.
  assign ica = ({ADDR_W{hold_sel}} & lca)
             | ({ADDR_W{psel}}     & pr)
             | ({ADDR_W{addsel}}   & add)
             | ({ADDR_W{cdsel}}    & cd)
             | ({ADDR_W{nlcasel}}  & nlca);

  // ==========================================================================
  // address register and incrementer
  // ==========================================================================
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      lca <= '0;                                        // start of microcode.
    end else begin
      lca <= ica;
    end
  end

  assign nlca = lca + 1'b1;                             // wraps at 16 bits.
  assign mca  = lca[MCA_W-1:0];                         // control-store address.

  // ==========================================================================
  // ecc high flag
  // ==========================================================================
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      eccr <= 1'b0;
    end else begin
      eccr <= ~eccr_hi_n;                               // active high, one cycle late.
    end
  end

  // the decoder must raise exactly one select in every cycle.
  a_sel_onehot : assert property (
    @(posedge mclk) disable iff (!rst_n)
    $onehot({hold_sel, psel, addsel, cdsel, nlcasel})
  );

endmodule

/* hdl/mac_top.sv */
`timescale 1ns/10ps

module mac_top (
  input  logic                        mclk,
  input  logic                        rst_n,
  input  logic [15:0]                 uword,
  input  logic [mac_pkg::COND_W-1:0]  cond,
  input  logic [mac_pkg::ADDR_W-1:0]  cd,
  input  logic                        hold,
  input  logic                        eccr_hi_n,
  output logic [mac_pkg::ADDR_W-1:0]  lca,
  output logic [mac_pkg::ADDR_W-1:0]  nlca,
  output logic [mac_pkg::MCA_W-1:0]   mca,
  output logic                        eccr,
  output logic                        stack_fault
);

  import mac_pkg::*;

  logic              hold_sel;
  logic              psel;
  logic              addsel;
  logic              cdsel;
  logic              nlcasel;
  logic              push;
  logic              pop;
  logic [ADDR_W-1:0] add;                               // branch target.
  logic [ADDR_W-1:0] pr;                                // return stack top.

  // ==========================================================================
  // decode and return stack side by side
  // ==========================================================================
  mac_branch_decode u_decode (
    .uword    (uword),
    .cond     (cond),
    .lca      (lca),
    .hold     (hold),
    .hold_sel (hold_sel),
    .psel     (psel),
    .addsel   (addsel),
    .cdsel    (cdsel),
    .nlcasel  (nlcasel),
    .add      (add),
    .push     (push),
    .pop      (pop)
  );

  mac_return_stack u_stack (
    .mclk        (mclk),
    .rst_n       (rst_n),
    .push        (push),
    .pop         (pop),
    .push_data   (nlca),                                // return to call + 1.
    .pr          (pr),
    .stack_fault (stack_fault)
  );

  // ==========================================================================
  // address selection and register
  // ==========================================================================
  mac_addr_select u_select (
    .mclk      (mclk),
    .rst_n     (rst_n),
    .hold_sel  (hold_sel),
    .psel      (psel),
    .addsel    (addsel),
    .cdsel     (cdsel),
    .nlcasel   (nlcasel),
    .eccr_hi_n (eccr_hi_n),
    .pr        (pr),
    .add       (add),
    .cd        (cd),
    .lca       (lca),
    .nlca      (nlca),
    .mca       (mca),
    .eccr      (eccr)
  );

endmodule

/* include/mac_vectors.svh */
`ifndef MAC_VECTORS_SVH
`define MAC_VECTORS_SVH

// columns: test, rst, uword, cond, cd, cd from $random, hold, eccr_hi_n,
// then lca, eccr and stack_fault expected after the next mclk edge.
task automatic load_vectors();
  // reset and sequential flow, spare codes 6 and 7 step like CONT.
  add_row(1, 0, jump_word(OP_CONT, 13'h0000), 8'h00, 16'h0000, 0, 0, 1, 16'h0001, 0, 0);
  add_row(1, 0, jump_word(OP_CONT, 13'h1ABC), 8'hFF, 16'hFFFF, 0, 0, 0, 16'h0002, 1, 0);
  add_row(1, 0, jump_word(OP_CONT, 13'h0000), 8'h00, 16'h0000, 0, 0, 0, 16'h0003, 1, 0);
  add_row(1, 0, jump_word(3'd6, 13'h0123), 8'h00, 16'h0000, 0, 0, 1, 16'h0004, 0, 0);
  add_row(1, 0, jump_word(3'd7, 13'h03FF), 8'h00, 16'h0000, 0, 0, 1, 16'h0005, 0, 0);

  // jumps, page 7 is used for the conditional ones.
  add_row(2, 0, jump_word(OP_JMP, 13'h1C05), 8'h00, 16'h0000, 0, 0, 0, 16'h1C05, 1, 0);
  add_row(2, 0, jump_word(OP_CONT, 13'h0000), 8'h00, 16'h0000, 0, 0, 1, 16'h1C06, 0, 0);
  add_row(2, 0, cond_word(3'd2, 10'h155), 8'h04, 16'h0000, 0, 0, 1, 16'h1D55, 0, 0);
  add_row(2, 0, cond_word(3'd5, 10'h000), 8'hDF, 16'h0000, 0, 0, 0, 16'h1D56, 1, 0);
  add_row(2, 0, cond_word(3'd7, 10'h3FF), 8'h80, 16'h0000, 0, 0, 0, 16'h1FFF, 1, 0);
  add_row(2, 0, jump_word(OP_CONT, 13'h0000), 8'h00, 16'h0000, 0, 0, 1, 16'h2000, 0, 0);
  add_row(2, 0, jump_word(OP_JCD, 13'h0000), 8'h00, 16'h0000, 1, 0, 0, 16'h0000, 1, 0);
  add_row(2, 0, jump_word(OP_JCD, 13'h1FFF), 8'h00, 16'h0000, 1, 0, 1, 16'h0000, 0, 0);
  add_row(2, 0, jump_word(OP_JMP, 13'h1FFF), 8'h00, 16'h5A5A, 0, 0, 1, 16'h1FFF, 0, 0);

  // nested call and return.
  add_row(3, 0, jump_word(OP_JMP, 13'h0100), 8'h00, 16'h0000, 0, 0, 1, 16'h0100, 0, 0);
  add_row(3, 0, jump_word(OP_CALL, 13'h0200), 8'h00, 16'h0000, 0, 0, 0, 16'h0200, 1, 0);
  add_row(3, 0, jump_word(OP_CONT, 13'h0000), 8'h00, 16'h0000, 0, 0, 1, 16'h0201, 0, 0);
  add_row(3, 0, jump_word(OP_CALL, 13'h0300), 8'h00, 16'h0000, 0, 0, 1, 16'h0300, 0, 0);
  add_row(3, 0, jump_word(OP_RET, 13'h0000), 8'h00, 16'h0000, 0, 0, 0, 16'h0202, 1, 0);
  add_row(3, 0, jump_word(OP_CONT, 13'h0000), 8'h00, 16'h0000, 0, 0, 1, 16'h0203, 0, 0);
  add_row(3, 0, jump_word(OP_RET, 13'h0000), 8'h00, 16'h0000, 0, 0, 1, 16'h0101, 0, 0);

  // hold freezes lca, a held CALL must not push 0x0401.
  add_row(4, 0, jump_word(OP_CALL, 13'h0400), 8'h00, 16'h0000, 0, 0, 1, 16'h0400, 0, 0);
  add_row(4, 0, jump_word(OP_CONT, 13'h0000), 8'h00, 16'h0000, 0, 1, 0, 16'h0400, 1, 0);
  add_row(4, 0, jump_word(OP_JMP, 13'h0ABC), 8'h00, 16'h0000, 0, 1, 1, 16'h0400, 0, 0);
  add_row(4, 0, jump_word(OP_CALL, 13'h0ABC), 8'h00, 16'h0000, 0, 1, 1, 16'h0400, 0, 0);
  add_row(4, 0, jump_word(OP_RET, 13'h0000), 8'h00, 16'h0000, 0, 1, 0, 16'h0400, 1, 0);
  add_row(4, 0, jump_word(OP_JCD, 13'h0000), 8'h00, 16'hBEEF, 0, 1, 1, 16'h0400, 0, 0);
  add_row(4, 0, jump_word(OP_RET, 13'h0000), 8'h00, 16'h0000, 0, 0, 1, 16'h0102, 0, 0);
  add_row(4, 0, jump_word(OP_CONT, 13'h0000), 8'h00, 16'h0000, 0, 0, 0, 16'h0103, 1, 0);

  // five calls overflow the stack, then an empty pop after a fresh reset.
  add_row(5, 0, jump_word(OP_CALL, 13'h0010), 8'h00, 16'h0000, 0, 0, 1, 16'h0010, 0, 0);
  add_row(5, 0, jump_word(OP_CALL, 13'h0020), 8'h00, 16'h0000, 0, 0, 1, 16'h0020, 0, 0);
  add_row(5, 0, jump_word(OP_CALL, 13'h0030), 8'h00, 16'h0000, 0, 0, 0, 16'h0030, 1, 0);
  add_row(5, 0, jump_word(OP_CALL, 13'h0040), 8'h00, 16'h0000, 0, 0, 1, 16'h0040, 0, 0);
  add_row(5, 0, jump_word(OP_CALL, 13'h0050), 8'h00, 16'h0000, 0, 0, 1, 16'h0050, 0, 1);
  add_row(5, 0, jump_word(OP_RET, 13'h0000), 8'h00, 16'h0000, 0, 0, 0, 16'h0041, 1, 1);
  add_row(5, 0, jump_word(OP_RET, 13'h0000), 8'h00, 16'h0000, 0, 0, 1, 16'h0031, 0, 1);
  add_row(5, 1, jump_word(OP_CONT, 13'h0000), 8'h00, 16'h0000, 0, 0, 0, 16'h0000, 0, 0);
  add_row(5, 0, jump_word(OP_RET, 13'h0000), 8'h00, 16'h0000, 0, 0, 1, 16'h0000, 0, 1);
  add_row(5, 0, jump_word(OP_CONT, 13'h0000), 8'h00, 16'h0000, 0, 0, 1, 16'h0001, 0, 1);

  // eccr follows the inverted eccr_hi_n.
  add_row(6, 0, jump_word(OP_CONT, 13'h0000), 8'h00, 16'h0000, 0, 0, 0, 16'h0002, 1, 1);
  add_row(6, 0, jump_word(OP_CONT, 13'h0000), 8'h00, 16'h0000, 0, 0, 1, 16'h0003, 0, 1);
  add_row(6, 0, jump_word(OP_CONT, 13'h0000), 8'h00, 16'h0000, 0, 0, 0, 16'h0004, 1, 1);
  add_row(6, 0, jump_word(OP_CONT, 13'h0000), 8'h00, 16'h0000, 0, 0, 0, 16'h0005, 1, 1);
  add_row(6, 0, jump_word(OP_CONT, 13'h0000), 8'h00, 16'h0000, 0, 0, 1, 16'h0006, 0, 1);
endtask

`endif

/* tests/mac_tb.sv */
`timescale 1ns/10ps

module mac_tb;

  import mac_pkg::*;

  localparam int MAX_ROWS       = 64;
  localparam int NUM_TESTS      = 6;
  localparam int RESET_CYCLES   = 4;
  localparam int DRIVE_DELAY    = 10;                   // inputs change after the edge.
  localparam int SAMPLE_DELAY   = 5;                    // outputs are read here.
  localparam int TIMEOUT_CYCLES = 200;

  logic                mclk;
  logic                rst_n;
  logic [15:0]         uword;
  logic [COND_W-1:0]   cond;
  logic [ADDR_W-1:0]   cd;
  logic                hold;
  logic                eccr_hi_n;
  logic [ADDR_W-1:0]   lca;
  logic [ADDR_W-1:0]   nlca;
  logic [MCA_W-1:0]    mca;
  logic                eccr;
  logic                stack_fault;

  // ==========================================================================
  // vector table storage
  // ==========================================================================
  int                  row_test    [MAX_ROWS];
  bit                  row_rst     [MAX_ROWS];
  logic [15:0]         row_uword   [MAX_ROWS];
  logic [COND_W-1:0]   row_cond    [MAX_ROWS];
  logic [ADDR_W-1:0]   row_cd      [MAX_ROWS];
  bit                  row_cd_rand [MAX_ROWS];         // cd comes from $random.
  bit                  row_hold    [MAX_ROWS];
  bit                  row_ecc_n   [MAX_ROWS];
  logic [ADDR_W-1:0]   row_lca     [MAX_ROWS];
  bit                  row_eccr    [MAX_ROWS];
  bit                  row_fault   [MAX_ROWS];

  int                  num_rows;
  int                  seed;
  int                  current_test;
  int                  check_count;
  int                  error_count;
  int                  tests_passed;
  int                  test_checks [NUM_TESTS+1];
  int                  test_errors [NUM_TESTS+1];
  string               test_name   [NUM_TESTS+1];

  mac_top dut0 (
    .mclk        (mclk),
    .rst_n       (rst_n),
    .uword       (uword),
    .cond        (cond),
    .cd          (cd),
    .hold        (hold),
    .eccr_hi_n   (eccr_hi_n),
    .lca         (lca),
    .nlca        (nlca),
    .mca         (mca),
    .eccr        (eccr),
    .stack_fault (stack_fault)
  );

  initial begin
    mclk = 1'b0;
    forever #50 mclk = ~mclk;                           // 100 ns period.
  end

  // ==========================================================================
  // table builders
  // ==========================================================================
  function automatic logic [15:0] jump_word(input logic [OP_W-1:0] op,
                                            input logic [TGT_W-1:0] target);
    mac_word_u word;
    word.jmp.op     = op;
    word.jmp.target = target;
    return word;
  endfunction

  function automatic logic [15:0] cond_word(input logic [CIDX_W-1:0] idx,
                                            input logic [DISP_W-1:0] disp);
    mac_word_u word;
    word.cnd.op   = OP_JCOND;
    word.cnd.idx  = idx;
    word.cnd.disp = disp;
    return word;
  endfunction

  task automatic add_row(input int test, input int rst, input logic [15:0] word,
                         input logic [COND_W-1:0] flags, input logic [ADDR_W-1:0] data,
                         input int data_rand, input int hold_in, input int ecc_n,
                         input logic [ADDR_W-1:0] exp_lca, input int exp_eccr,
                         input int exp_fault);
    row_test[num_rows]    = test;
    row_rst[num_rows]     = (rst != 0);
    row_uword[num_rows]   = word;
    row_cond[num_rows]    = flags;
    row_cd[num_rows]      = data;
    row_cd_rand[num_rows] = (data_rand != 0);
    row_hold[num_rows]    = (hold_in != 0);
    row_ecc_n[num_rows]   = (ecc_n != 0);
    row_lca[num_rows]     = exp_lca;
    row_eccr[num_rows]    = (exp_eccr != 0);
    row_fault[num_rows]   = (exp_fault != 0);
    num_rows++;
  endtask

  `include "mac_vectors.svh"

  // ==========================================================================
  // checking and reporting
  // ==========================================================================
  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    check_count++;
    test_checks[current_test]++;
    assert (actual === expected) else begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
      error_count++;
      test_errors[current_test]++;
    end
  endtask

  task automatic check_outputs(input logic [15:0] exp_lca, input bit exp_eccr,
                               input bit exp_fault);
    logic [15:0] exp_nlca;
    exp_nlca = exp_lca + 16'd1;                         // wraps at 16 bits.
    check_value("lca", exp_lca, lca);
    check_value("nlca", exp_nlca, nlca);
    check_value("mca", 16'(exp_lca[MCA_W-1:0]), 16'(mca));
    check_value("eccr", 16'(exp_eccr), 16'(eccr));
    check_value("stack_fault", 16'(exp_fault), 16'(stack_fault));
  endtask

  task automatic report_test(input int t);
    $display("test %0d (%s): %0d checks, %0d errors", t, test_name[t],
             test_checks[t], test_errors[t]);
    if (test_errors[t] == 0) begin
      tests_passed++;
    end
  endtask

  // watchdog so a stuck run still ends.
  initial begin
    int n;
    n = 0;
    while (n < TIMEOUT_CYCLES) begin
      @(posedge mclk);
      n++;
    end
    $display("timeout: the vector table did not finish in %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin
    int          i;
    int          n;
    logic [31:0] rnd;
    logic [15:0] exp_lca;
    rst_n        = 1'b0;
    uword        = '0;
    cond         = '0;
    cd           = '0;
    hold         = 1'b1;                                // keeps lca at 0 on release.
    eccr_hi_n    = 1'b1;
    seed         = 32'h998a;
    num_rows     = 0;
    check_count  = 0;
    error_count  = 0;
    tests_passed = 0;
    current_test = 1;
    for (i = 0; i <= NUM_TESTS; i++) begin
      test_checks[i] = 0;
      test_errors[i] = 0;
    end
    test_name[1] = "reset and sequential flow";
    test_name[2] = "jumps";
    test_name[3] = "call and return";
    test_name[4] = "hold";
    test_name[5] = "stack faults";
    test_name[6] = "eccr";
    load_vectors();

    n = 0;
    while (n < RESET_CYCLES) begin
      @(posedge mclk);
      n++;
    end
    #DRIVE_DELAY;
    rst_n = 1'b1;
    check_outputs(16'h0000, 1'b0, 1'b0);                // reset state.

    for (i = 0; i < num_rows; i++) begin
      current_test = row_test[i];
      rst_n        = ~row_rst[i];
      uword        = row_uword[i];
      cond         = row_cond[i];
      hold         = row_hold[i];
      eccr_hi_n    = row_ecc_n[i];
      if (row_cd_rand[i]) begin
        rnd = $random(seed);
        cd  = rnd[15:0];
      end else begin
        cd = row_cd[i];
      end
      exp_lca = (row_cd_rand[i] && !row_hold[i]) ? cd : row_lca[i];
      @(posedge mclk);
      #SAMPLE_DELAY;
      check_outputs(exp_lca, row_eccr[i], row_fault[i]);
      if ((i == num_rows - 1) || (row_test[i+1] != row_test[i])) begin
        report_test(row_test[i]);
      end
      #(DRIVE_DELAY - SAMPLE_DELAY);
    end

    $display("summary: %0d of %0d tests passed, %0d checks, %0d errors",
             tests_passed, NUM_TESTS, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+include
hdl/mac_pkg.sv
hdl/mac_branch_decode.sv
hdl/mac_return_stack.sv
hdl/mac_addr_select.sv
hdl/mac_top.sv
tests/mac_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the microaddress path testbench with Verilator and run it.
# The result comes from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_LOG=build.log

rm -rf obj_dir

verilator --binary --timing --assert -Mdir obj_dir -f build.f \
  --top-module mac_tb -o mac_tb_sim > "$BUILD_LOG" 2>&1 \
  || { cat "$BUILD_LOG"; echo "run_sim: build error, see $BUILD_LOG"; exit 1; }

./obj_dir/mac_tb_sim > "$LOG" 2>&1 \
  || { cat "$LOG"; echo "run_sim: simulator exited with an error"; exit 1; }

cat "$LOG"

grep -q "Simulation failed" "$LOG" \
  && { echo "run_sim: FAIL"; exit 1; }

grep -q "Simulation passed" "$LOG" \
  || { echo "run_sim: no result line in $LOG"; exit 1; }

echo "run_sim: PASS"
exit 0
